//--- design/sha256_config.svh
// SHA-256 accelerator configuration
// Bus widths, register map, control bits and identification words
`ifndef SHA256_CONFIG_SVH
`define SHA256_CONFIG_SVH

// Bus geometry
`define SHA256_DATA_WIDTH        32
`define SHA256_ADDR_WIDTH        12

// ----------------------------------------
// Register byte addresses
// ----------------------------------------
`define SHA256_ADDR_NAME0        12'h000
`define SHA256_ADDR_NAME1        12'h004
`define SHA256_ADDR_VERSION0     12'h008
`define SHA256_ADDR_VERSION1     12'h00C
`define SHA256_ADDR_CTRL         12'h010
`define SHA256_ADDR_STATUS       12'h014
`define SHA256_ADDR_BLOCK_START  12'h040
`define SHA256_ADDR_BLOCK_END    12'h07C
`define SHA256_ADDR_DIGEST_START 12'h080
`define SHA256_ADDR_DIGEST_END   12'h09C
`define SHA256_ADDR_INTR_EN      12'h100
`define SHA256_ADDR_NOTIF_STS    12'h104
`define SHA256_ADDR_ERR_STS      12'h108

// CTRL register bits
`define SHA256_CTRL_INIT_BIT     0
`define SHA256_CTRL_NEXT_BIT     1

// Identification words, ASCII "sha2", "-256", "1.00"
`define SHA256_CORE_NAME0        32'h73686132
`define SHA256_CORE_NAME1        32'h2d323536
`define SHA256_CORE_VERSION0     32'h312e3030
`define SHA256_CORE_VERSION1     32'h00000000

`endif

//--- design/sha256_pkg.sv
// SHA-256 shared types, constants and round functions
// Command and state encodings, round constant table, initial hash
`include "sha256_config.svh"

package sha256_pkg;

  // Command opcodes from the register block
  typedef enum logic [1:0] {
    CMD_NONE = 2'b00,
    CMD_INIT = 2'b01,
    CMD_NEXT = 2'b10
  } sha256_cmd_e;

  // Compression engine states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_ROUNDS = 2'b01,
    ST_FINISH = 2'b10
  } sha256_state_e;

  // ----------------------------------------
  // Constants from FIPS 180-4
  // ----------------------------------------
  parameter logic [`SHA256_DATA_WIDTH-1:0] SHA256_K [0:63] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash value, word 0 is the most significant
  parameter logic [0:7][`SHA256_DATA_WIDTH-1:0] SHA256_H0 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // ----------------------------------------
  // Round functions
  // ----------------------------------------
  function automatic logic [`SHA256_DATA_WIDTH-1:0] rotr(
    input logic [`SHA256_DATA_WIDTH-1:0] x,
    input int unsigned                   n
  );
    return (x >> n) | (x << (`SHA256_DATA_WIDTH - n));
  endfunction

  function automatic logic [`SHA256_DATA_WIDTH-1:0] big_sigma0(
    input logic [`SHA256_DATA_WIDTH-1:0] x
  );
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [`SHA256_DATA_WIDTH-1:0] big_sigma1(
    input logic [`SHA256_DATA_WIDTH-1:0] x
  );
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  // Schedule expansion terms
  function automatic logic [`SHA256_DATA_WIDTH-1:0] small_sigma0(
    input logic [`SHA256_DATA_WIDTH-1:0] x
  );
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [`SHA256_DATA_WIDTH-1:0] small_sigma1(
    input logic [`SHA256_DATA_WIDTH-1:0] x
  );
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic logic [`SHA256_DATA_WIDTH-1:0] choose(
    input logic [`SHA256_DATA_WIDTH-1:0] e,
    input logic [`SHA256_DATA_WIDTH-1:0] f,
    input logic [`SHA256_DATA_WIDTH-1:0] g
  );
    return (e & f) ^ (~e & g);
  endfunction

  function automatic logic [`SHA256_DATA_WIDTH-1:0] majority(
    input logic [`SHA256_DATA_WIDTH-1:0] a,
    input logic [`SHA256_DATA_WIDTH-1:0] b,
    input logic [`SHA256_DATA_WIDTH-1:0] c
  );
    return (a & b) ^ (a & c) ^ (b & c);
  endfunction

endpackage

//--- design/sha256_core_if.sv
// SHA-256 core link
// Commands and message block in, digest and handshake flags out
`timescale 1ns/1ps
`include "sha256_config.svh"

interface sha256_core_if;

  // Single-cycle opcode pulse, CMD_NONE otherwise
  sha256_pkg::sha256_cmd_e cmd;
  // Message block, word 0 in the top bits
  logic [`SHA256_DATA_WIDTH*16-1:0] block;
  // Engine idle and able to take a command
  logic ready;
  // Hash state after the last block
  logic [`SHA256_DATA_WIDTH*8-1:0] digest;
  logic digest_valid;

  // Register decode side
  modport ctrl (
    output cmd,
    output block
  );

  // Compression engine side
  modport engine (
    input  cmd,
    input  block,
    output ready,
    output digest,
    output digest_valid
  );

  // Result and interrupt side, observe only
  modport mon (
    input cmd,
    input ready,
    input digest,
    input digest_valid
  );

endinterface

//--- design/sha256_reg_decode.sv
// SHA-256 register decode
// Address decode, block word storage, command pulses and read mux
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_reg_decode (
  input  logic                                clk,
  input  logic                                reset_n,
  // Bus side
  input  logic                                cs,
  input  logic                                we,
  input  logic [`SHA256_ADDR_WIDTH-1:0]       address,
  input  logic [`SHA256_DATA_WIDTH-1:0]       write_data,
  output logic [`SHA256_DATA_WIDTH-1:0]       read_data,
  output logic                                err,
  // Toward the engine
  sha256_core_if.ctrl                         core,
  // Result block readback
  input  logic [0:7][`SHA256_DATA_WIDTH-1:0]  digest_word,
  input  logic                                ready_flag,
  input  logic                                valid_flag,
  input  logic [1:0]                          intr_en,
  input  logic                                notif_sts,
  input  logic                                err_sts,
  // Result block write strobes
  output logic                                en_we,
  output logic                                notif_w1c,
  output logic                                err_w1c,
  output logic                                bad_access
);

  logic                               wr;
  logic                               block_hit;
  logic                               digest_hit;
  logic                               mapped;
  logic [0:15][`SHA256_DATA_WIDTH-1:0] block_q;
  sha256_pkg::sha256_cmd_e            cmd_q;

  assign wr = cs & we;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  // Range windows hit only word-aligned addresses
  assign block_hit  = (address >= `SHA256_ADDR_BLOCK_START) &&
                      (address <= `SHA256_ADDR_BLOCK_END) && (address[1:0] == 2'b00);
  assign digest_hit = (address >= `SHA256_ADDR_DIGEST_START) &&
                      (address <= `SHA256_ADDR_DIGEST_END) && (address[1:0] == 2'b00);

  // Interrupt register write strobes
  assign en_we     = wr && (address == `SHA256_ADDR_INTR_EN);
  assign notif_w1c = wr && (address == `SHA256_ADDR_NOTIF_STS);
  assign err_w1c   = wr && (address == `SHA256_ADDR_ERR_STS);

  // Message block word storage
  always_ff @(posedge clk)
  begin
    if (wr && block_hit)
    begin
      block_q[address[5:2]] <= write_data;
    end
  end

  assign core.block = block_q;

  // CTRL write becomes a one-cycle opcode
  // Init wins over next when both bits are set
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cmd_q <= sha256_pkg::CMD_NONE;
    end
    else if (wr && (address == `SHA256_ADDR_CTRL) && write_data[`SHA256_CTRL_INIT_BIT])
    begin
      cmd_q <= sha256_pkg::CMD_INIT;
    end
    else if (wr && (address == `SHA256_ADDR_CTRL) && write_data[`SHA256_CTRL_NEXT_BIT])
    begin
      cmd_q <= sha256_pkg::CMD_NEXT;
    end
    else
    begin
      cmd_q <= sha256_pkg::CMD_NONE;
    end
  end

  assign core.cmd = cmd_q;

  // ----------------------------------------
  // Read multiplexer
  // ----------------------------------------
  always_comb
  begin
    read_data = '0;
    mapped    = 1'b1;
    if (block_hit)
    begin
      read_data = block_q[address[5:2]];
    end
    else if (digest_hit)
    begin
      read_data = digest_word[address[4:2]];
    end
    else
    begin
      case (address)
        `SHA256_ADDR_NAME0:     read_data = `SHA256_CORE_NAME0;
        `SHA256_ADDR_NAME1:     read_data = `SHA256_CORE_NAME1;
        `SHA256_ADDR_VERSION0:  read_data = `SHA256_CORE_VERSION0;
        `SHA256_ADDR_VERSION1:  read_data = `SHA256_CORE_VERSION1;
        // Pending command pulse shows for its single cycle
        `SHA256_ADDR_CTRL:
        begin
          read_data[`SHA256_CTRL_INIT_BIT] = (cmd_q == sha256_pkg::CMD_INIT);
          read_data[`SHA256_CTRL_NEXT_BIT] = (cmd_q == sha256_pkg::CMD_NEXT);
        end
        `SHA256_ADDR_STATUS:    read_data[1:0] = {valid_flag, ready_flag};
        `SHA256_ADDR_INTR_EN:   read_data[1:0] = intr_en;
        `SHA256_ADDR_NOTIF_STS: read_data[0]   = notif_sts;
        `SHA256_ADDR_ERR_STS:   read_data[0]   = err_sts;
        default:                mapped         = 1'b0;
      endcase
    end
  end

  // Unmapped reads raise err
  // Any unmapped access sets the error status
  assign err        = cs & ~we & ~mapped;
  assign bad_access = cs & ~mapped;

endmodule

//--- design/sha256_round_core.sv
// SHA-256 compression engine
// One round per cycle over a sliding sixteen-word schedule window
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_round_core (
  input  logic          clk,
  input  logic          reset_n,
  sha256_core_if.engine core
);

  sha256_pkg::sha256_state_e           state_q;
  logic [5:0]                          round_q;
  logic                                valid_q;
  logic                                start;
  // Hash state H0..H7 and working variables a..h
  logic [0:7][`SHA256_DATA_WIDTH-1:0]  hash_q;
  logic [0:7][`SHA256_DATA_WIDTH-1:0]  work_q;
  // Schedule window, entry 0 is W[t] of the current round
  logic [0:15][`SHA256_DATA_WIDTH-1:0] w_q;
  logic [`SHA256_DATA_WIDTH-1:0]       w_next;
  logic [`SHA256_DATA_WIDTH-1:0]       t1;
  logic [`SHA256_DATA_WIDTH-1:0]       t2;

  // Commands only land while idle, busy ones are dropped
  assign start = (state_q == sha256_pkg::ST_IDLE) && (core.cmd != sha256_pkg::CMD_NONE);

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= sha256_pkg::ST_IDLE;
      round_q <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        sha256_pkg::ST_IDLE:
        begin
          if (start)
          begin
            state_q <= sha256_pkg::ST_ROUNDS;
            round_q <= '0;
            valid_q <= 1'b0;
          end
        end
        // 64 rounds, counter wraps back to zero
        sha256_pkg::ST_ROUNDS:
        begin
          round_q <= round_q + 6'd1;
          if (round_q == 6'd63)
          begin
            state_q <= sha256_pkg::ST_FINISH;
          end
        end
        sha256_pkg::ST_FINISH:
        begin
          state_q <= sha256_pkg::ST_IDLE;
          valid_q <= 1'b1;
        end
        default:
        begin
          state_q <= sha256_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Round datapath
  // ----------------------------------------
  always_comb
  begin
    // T1 = h + S1(e) + Ch(e,f,g) + K[t] + W[t]
    t1 = work_q[7] + sha256_pkg::big_sigma1(work_q[4]) +
         sha256_pkg::choose(work_q[4], work_q[5], work_q[6]) +
         sha256_pkg::SHA256_K[round_q] + w_q[0];
    // T2 = S0(a) + Maj(a,b,c)
    t2 = sha256_pkg::big_sigma0(work_q[0]) +
         sha256_pkg::majority(work_q[0], work_q[1], work_q[2]);
    // W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
    w_next = sha256_pkg::small_sigma1(w_q[14]) + w_q[9] +
             sha256_pkg::small_sigma0(w_q[1]) + w_q[0];
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      w_q <= core.block;
      // Init restarts from H0, next chains on the previous hash
      if (core.cmd == sha256_pkg::CMD_INIT)
      begin
        hash_q <= sha256_pkg::SHA256_H0;
        work_q <= sha256_pkg::SHA256_H0;
      end
      else
      begin
        work_q <= hash_q;
      end
    end
    else if (state_q == sha256_pkg::ST_ROUNDS)
    begin
      w_q    <= {w_q[1:15], w_next};
      work_q <= {t1 + t2, work_q[0:2], work_q[3] + t1, work_q[4:6]};
    end
    else if (state_q == sha256_pkg::ST_FINISH)
    begin
      for (int i = 0; i < 8; i++)
      begin
        hash_q[i] <= hash_q[i] + work_q[i];
      end
    end
  end

  // Ready tracks the idle state directly
  assign core.ready        = (state_q == sha256_pkg::ST_IDLE);
  assign core.digest       = hash_q;
  assign core.digest_valid = valid_q;

endmodule

//--- design/sha256_digest_intr.sv
// SHA-256 result and interrupt block
// Digest capture, status flags, interrupt enable and W1C status
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_digest_intr (
  input  logic                               clk,
  input  logic                               reset_n,
  sha256_core_if.mon                         core,
  // Strobes from register decode
  input  logic                               en_we,
  input  logic                               notif_w1c,
  input  logic                               err_w1c,
  input  logic                               bad_access,
  input  logic [`SHA256_DATA_WIDTH-1:0]      write_data,
  // Readback toward decode
  output logic [0:7][`SHA256_DATA_WIDTH-1:0] digest_word,
  output logic                               ready_flag,
  output logic                               valid_flag,
  output logic [1:0]                         intr_en,
  output logic                               notif_sts,
  output logic                               err_sts,
  // Interrupt lines
  output logic                               notif_intr,
  output logic                               error_intr
);

  logic accept;
  logic done_rise;

  // Engine takes a command this cycle
  assign accept    = core.ready && (core.cmd != sha256_pkg::CMD_NONE);
  // valid_flag lags digest_valid by one cycle
  assign done_rise = core.digest_valid & ~valid_flag;

  // Digest words only change on a finished hash
  always_ff @(posedge clk)
  begin
    if (core.digest_valid)
    begin
      digest_word <= core.digest;
    end
  end

  // ----------------------------------------
  // Flags and interrupt registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ready_flag <= 1'b1;
      valid_flag <= 1'b0;
      intr_en    <= 2'b00;
      notif_sts  <= 1'b0;
      err_sts    <= 1'b0;
    end
    else
    begin
      // Drop both flags as soon as a command is taken
      if (accept)
      begin
        ready_flag <= 1'b0;
        valid_flag <= 1'b0;
      end
      else
      begin
        ready_flag <= core.ready;
        valid_flag <= core.digest_valid;
      end
      if (en_we)
      begin
        intr_en <= write_data[1:0];
      end
      // Hardware set beats a same-cycle clear
      notif_sts <= done_rise | (notif_sts & ~(notif_w1c & write_data[0]));
      err_sts   <= bad_access | (err_sts & ~(err_w1c & write_data[0]));
    end
  end

  assign notif_intr = notif_sts & intr_en[0];
  assign error_intr = err_sts & intr_en[1];

endmodule

//--- design/sha256_top.sv
// SHA-256 accelerator top level
// Register decode, compression engine and result block on one bus
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_top (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          cs,
  input  logic                          we,
  input  logic [`SHA256_ADDR_WIDTH-1:0] address,
  input  logic [`SHA256_DATA_WIDTH-1:0] write_data,
  output logic [`SHA256_DATA_WIDTH-1:0] read_data,
  output logic                          err,
  output logic                          error_intr,
  output logic                          notif_intr
);

  logic [0:7][`SHA256_DATA_WIDTH-1:0] digest_word;
  logic                               ready_flag;
  logic                               valid_flag;
  logic [1:0]                         intr_en;
  logic                               notif_sts;
  logic                               err_sts;
  logic                               en_we;
  logic                               notif_w1c;
  logic                               err_w1c;
  logic                               bad_access;

  // Command, block and digest link
  sha256_core_if u_core_if ();

  sha256_reg_decode u_decode (
    .clk         (clk),
    .reset_n     (reset_n),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .err         (err),
    .core        (u_core_if.ctrl),
    .digest_word (digest_word),
    .ready_flag  (ready_flag),
    .valid_flag  (valid_flag),
    .intr_en     (intr_en),
    .notif_sts   (notif_sts),
    .err_sts     (err_sts),
    .en_we       (en_we),
    .notif_w1c   (notif_w1c),
    .err_w1c     (err_w1c),
    .bad_access  (bad_access)
  );

  sha256_round_core u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .core    (u_core_if.engine)
  );

  sha256_digest_intr u_result (
    .clk         (clk),
    .reset_n     (reset_n),
    .core        (u_core_if.mon),
    .en_we       (en_we),
    .notif_w1c   (notif_w1c),
    .err_w1c     (err_w1c),
    .bad_access  (bad_access),
    .write_data  (write_data),
    .digest_word (digest_word),
    .ready_flag  (ready_flag),
    .valid_flag  (valid_flag),
    .intr_en     (intr_en),
    .notif_sts   (notif_sts),
    .err_sts     (err_sts),
    .notif_intr  (notif_intr),
    .error_intr  (error_intr)
  );

endmodule

//--- test/sha256_clk_gen.sv
// Testbench clock and reset source
// Free-running clock with reset held low for a set number of cycles
`timescale 1ns/1ps

module sha256_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic reset_n
);

  // Free-running clock, 50 percent duty
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release reset just after an edge, same as the bus stimulus
  initial
  begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset_n = 1'b1;
  end

endmodule

//--- test/sha256_properties.sv
// SHA-256 top level bus and interrupt properties
// Bound onto the top level, watches interrupt masking and read responses
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_properties (
  input logic                          clk,
  input logic                          reset_n,
  input logic                          cs,
  input logic                          we,
  input logic [`SHA256_DATA_WIDTH-1:0] read_data,
  input logic                          err,
  input logic                          error_intr,
  input logic                          notif_intr,
  input logic [1:0]                    intr_en
);

  // ----------------------------------------
  // Interrupt masking
  // ----------------------------------------
  a_notif_masked: assert property (@(posedge clk) disable iff (!reset_n)
    !intr_en[0] |-> !notif_intr)
  else $error("notif_intr high while its enable bit is clear");

  a_error_masked: assert property (@(posedge clk) disable iff (!reset_n)
    !intr_en[1] |-> !error_intr)
  else $error("error_intr high while its enable bit is clear");

  // ----------------------------------------
  // Bus responses
  // ----------------------------------------
  // err only answers a read
  a_err_read_only: assert property (@(posedge clk) disable iff (!reset_n)
    err |-> (cs && !we))
  else $error("err high outside a read access");

  a_read_known: assert property (@(posedge clk) disable iff (!reset_n)
    (cs && !we) |-> !$isunknown(read_data))
  else $error("read_data unknown during a read access");

endmodule

// Attach to every instance of the accelerator top
bind sha256_top sha256_properties u_props (
  .clk        (clk),
  .reset_n    (reset_n),
  .cs         (cs),
  .we         (we),
  .read_data  (read_data),
  .err        (err),
  .error_intr (error_intr),
  .notif_intr (notif_intr),
  .intr_en    (intr_en)
);

//--- test/sha256_tb.sv
// SHA-256 accelerator directed testbench
// Register bus tasks, known hash vectors, interrupt checks and a watchdog
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_tb;

  localparam int CLK_PERIOD      = 20;
  localparam int DRIVE_DELAY     = 2;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int POLL_LIMIT      = 200;

  // Standard digests for "abc" and the 448-bit two-block message
  localparam logic [255:0] ABC_DIGEST =
    256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
  localparam logic [255:0] TWO_BLOCK_DIGEST =
    256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1;

  logic                          clk;
  logic                          reset_n;
  logic                          cs;
  logic                          we;
  logic [`SHA256_ADDR_WIDTH-1:0] address;
  logic [`SHA256_DATA_WIDTH-1:0] write_data;
  logic [`SHA256_DATA_WIDTH-1:0] read_data;
  logic                          err;
  logic                          error_intr;
  logic                          notif_intr;
  integer                        seed;

  sha256_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (16)
  ) u_clk_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  sha256_top u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err),
    .error_intr (error_intr),
    .notif_intr (notif_intr)
  );

  // ----------------------------------------
  // Check and bus helpers
  // ----------------------------------------
  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped on failure");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERR %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Write lands on the next edge and the strobes drop after it
  task automatic write_word(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    #DRIVE_DELAY;
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(posedge clk);
    #DRIVE_DELAY;
    cs = 1'b0;
    we = 1'b0;
  endtask

  // Combinational read sampled mid-cycle
  task automatic read_word(input logic [11:0] addr, output logic [31:0] data,
                           output logic err_seen);
    @(posedge clk);
    #DRIVE_DELAY;
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    #(CLK_PERIOD / 2);
    data     = read_data;
    err_seen = err;
    @(posedge clk);
    #DRIVE_DELAY;
    cs = 1'b0;
  endtask

  // Word 0 sits in the top bits of the block
  task automatic write_block(input logic [511:0] blk);
    for (int i = 0; i < 16; i++)
    begin
      write_word(`SHA256_ADDR_BLOCK_START + 12'(i * 4), blk[511 - 32 * i -: 32]);
    end
  endtask

  // Poll STATUS until the valid bit shows
  task automatic wait_done();
    logic [31:0] status;
    logic        err_seen;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[1])
    begin
      read_word(`SHA256_ADDR_STATUS, status, err_seen);
      polls++;
      if (!status[1] && polls >= POLL_LIMIT)
      begin
        $display("Core did not report done within %0d status polls", POLL_LIMIT);
        abort_run();
      end
    end
  endtask

  task automatic check_digest(input string name, input logic [255:0] exp);
    logic [31:0] data;
    logic        err_seen;
    for (int i = 0; i < 8; i++)
    begin
      read_word(`SHA256_ADDR_DIGEST_START + 12'(i * 4), data, err_seen);
      check_word($sformatf("%s digest word %0d", name, i), data, exp[255 - 32 * i -: 32]);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic reset_defaults();
    logic [31:0] data;
    logic        err_seen;
    read_word(`SHA256_ADDR_NAME0, data, err_seen);
    check_word("NAME0", data, "sha2");
    read_word(`SHA256_ADDR_NAME1, data, err_seen);
    check_word("NAME1", data, "-256");
    read_word(`SHA256_ADDR_VERSION0, data, err_seen);
    check_word("VERSION0", data, "1.00");
    read_word(`SHA256_ADDR_VERSION1, data, err_seen);
    check_word("VERSION1", data, 32'h0);
    // Ready and not valid
    read_word(`SHA256_ADDR_STATUS, data, err_seen);
    check_word("STATUS after reset", data, 32'h1);
    read_word(`SHA256_ADDR_CTRL, data, err_seen);
    check_word("CTRL after reset", data, 32'h0);
    check_word("notif_intr after reset", {31'b0, notif_intr}, 32'h0);
    check_word("error_intr after reset", {31'b0, error_intr}, 32'h0);
  endtask

  task automatic block_readback();
    logic [31:0] words [16];
    logic [31:0] data;
    logic        err_seen;
    for (int i = 0; i < 16; i++)
    begin
      words[i] = $random(seed);
      write_word(`SHA256_ADDR_BLOCK_START + 12'(i * 4), words[i]);
    end
    for (int i = 0; i < 16; i++)
    begin
      read_word(`SHA256_ADDR_BLOCK_START + 12'(i * 4), data, err_seen);
      check_word($sformatf("block word %0d", i), data, words[i]);
    end
  endtask

  task automatic hash_abc();
    logic [31:0] data;
    logic        err_seen;
    // Completion interrupt on
    write_word(`SHA256_ADDR_INTR_EN, 32'h1);
    write_block({32'h61626380, {14{32'h0}}, 32'h00000018});
    write_word(`SHA256_ADDR_CTRL, 32'h1 << `SHA256_CTRL_INIT_BIT);
    wait_done();
    check_digest("abc", ABC_DIGEST);
    check_word("notif_intr after abc", {31'b0, notif_intr}, 32'h1);
    // Write one to clear
    write_word(`SHA256_ADDR_NOTIF_STS, 32'h1);
    check_word("notif_intr after clear", {31'b0, notif_intr}, 32'h0);
    read_word(`SHA256_ADDR_NOTIF_STS, data, err_seen);
    check_word("NOTIF_STS after clear", data, 32'h0);
  endtask

  task automatic hash_two_blocks();
    write_block({32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
                 32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
                 32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
                 32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000});
    write_word(`SHA256_ADDR_CTRL, 32'h1 << `SHA256_CTRL_INIT_BIT);
    wait_done();
    // Second block only carries the length
    write_block({{15{32'h0}}, 32'h000001c0});
    write_word(`SHA256_ADDR_CTRL, 32'h1 << `SHA256_CTRL_NEXT_BIT);
    // Init while busy must be dropped
    repeat (10) @(posedge clk);
    write_word(`SHA256_ADDR_CTRL, 32'h1 << `SHA256_CTRL_INIT_BIT);
    wait_done();
    check_digest("two-block", TWO_BLOCK_DIGEST);
  endtask

  task automatic unmapped_access();
    logic [31:0] data;
    logic        err_seen;
    // Error interrupt on with completion off
    write_word(`SHA256_ADDR_INTR_EN, 32'h2);
    read_word(12'h200, data, err_seen);
    check_word("err on unmapped read", {31'b0, err_seen}, 32'h1);
    read_word(`SHA256_ADDR_ERR_STS, data, err_seen);
    check_word("ERR_STS after unmapped read", data, 32'h1);
    check_word("error_intr after unmapped read", {31'b0, error_intr}, 32'h1);
    write_word(`SHA256_ADDR_ERR_STS, 32'h1);
    read_word(`SHA256_ADDR_ERR_STS, data, err_seen);
    check_word("ERR_STS after clear", data, 32'h0);
    check_word("error_intr after clear", {31'b0, error_intr}, 32'h0);
    // Unmapped write sets the status again
    write_word(12'h200, 32'hdeadbeef);
    read_word(`SHA256_ADDR_ERR_STS, data, err_seen);
    check_word("ERR_STS after unmapped write", data, 32'h1);
    check_word("error_intr after unmapped write", {31'b0, error_intr}, 32'h1);
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial
  begin
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    seed       = 33464;
    @(posedge reset_n);
    reset_defaults();
    block_readback();
    hash_abc();
    hash_two_blocks();
    unmapped_access();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Watchdog expired after %0d cycles, tests did not complete",
             NUM_TESTS * CYCLES_PER_TEST);
    abort_run();
  end

endmodule

//--- sim.f
+incdir+design
design/sha256_pkg.sv
design/sha256_core_if.sv
design/sha256_reg_decode.sv
design/sha256_round_core.sv
design/sha256_digest_intr.sv
design/sha256_top.sv
test/sha256_clk_gen.sv
test/sha256_properties.sv
test/sha256_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the SHA-256 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sha256_tb -f sim.f --Mdir obj_dir -o sim_sha256
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_sha256)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi
